/* Bender.yml */
package:
  name: athena_ctrl

sources:
  - files:
      - hw/athena_cfg_pkg.sv
      - hw/athena_ctrl_pkg.sv
      - hw/ioctl_cfg_capture.sv
      - hw/joystick_mapper.sv
      - hw/osd_settings_out.sv
      - hw/athena_ctrl_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/athena_ctrl_tb.sv

/* athena_ctrl_top.f */
+incdir+sim
hw/athena_cfg_pkg.sv
hw/athena_ctrl_pkg.sv
hw/ioctl_cfg_capture.sv
hw/joystick_mapper.sv
hw/osd_settings_out.sv
hw/athena_ctrl_top.sv
sim/athena_ctrl_tb.sv

/* hw/athena_cfg_pkg.sv */
// Host side types and constants shared by download capture, OSD settings and the testbench
package athena_cfg_pkg;

	// ==================================================
	// Download channel
	// ==================================================

	// Download indexes
	localparam logic [7:0] IDX_GAME = 8'd1;
	localparam logic [7:0] IDX_DIP  = 8'd254;

	// Number of DIP switch bytes held
	localparam int DIP_BYTES = 8;

	// One host download beat
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

	// Game identifier from the MRA
	typedef logic [7:0] game_id_t;

	localparam game_id_t GAME_ATHENA       = 8'h02;
	localparam game_id_t GAME_COUNTRY_GOLF = 8'h14;

	// DIP banks as the core sees them
	typedef struct packed {
		logic [7:0] dsw2;
		logic [7:0] dsw1;
	} dsw_t;

	// ==================================================
	// OSD status word
	// ==================================================

	localparam logic [15:0] MENU_MASK_DEFAULT = 16'hff;
	localparam int          ASPECT_W          = 13;

	// Layer disable bits, set means hidden
	typedef struct packed {
		logic front;
		logic back;
		logic side;
	} layer_off_t;

	// Low 32 status bits
	typedef struct packed {
		logic [9:0] spare_31_22;
		logic [1:0] db15_mode;
		logic       core_flip;
		layer_off_t layer_off;
		logic       spare_15;
		logic       vga_scaler;
		logic [2:0] spare_13_11;
		logic       orient_vert;
		logic [1:0] aspect;
		logic       spare_7;
		logic [2:0] scan_fx;
		logic [2:0] spare_3_1;
		logic       reset_req;
	} osd_status_t;

endpackage

/* hw/athena_ctrl_pkg.sv */
// Controller side types for joystick decoding, player input words and trackball words
package athena_ctrl_pkg;

	// ==================================================
	// Joystick sources
	// ==================================================

	// USB gamepad layout from the host, active high
	typedef struct packed {
		logic [5:0] spare_15_10;
		logic       pause;
		logic       service;
		logic       coin;
		logic       start;
		logic       btn2;
		logic       btn1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_usb_t;

	// DB15 arcade stick layout, active high
	typedef struct packed {
		logic [3:0] spare_15_12;
		logic       select;
		logic       start;
		// D E F buttons not wired to this game
		logic [2:0] spare_9_7;
		logic       c;
		logic       b;
		logic       a;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_db15_t;

	// Same 16 bit word read either way
	typedef union packed {
		joy_usb_t  usb;
		joy_db15_t db15;
	} joy_word_u;

	// ==================================================
	// Core side words
	// ==================================================

	// Player word, active low
	typedef struct packed {
		logic [1:0] ones_hi;
		logic       up;
		logic       down;
		logic       right;
		logic       left;
		logic       service;
		logic [4:0] ones_lo;
		logic       btn2;
		logic       btn1;
		logic       start;
		logic       coin;
	} player_word_t;

	// Trackball position pair
	typedef struct packed {
		logic       zero_y;
		logic [6:0] y;
		logic       zero_x;
		logic [6:0] x;
	} trackball_t;

	// Analog stick, range -127..127
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} analog_t;

endpackage

/* hw/athena_ctrl_top.sv */
// Top level of the control glue, ties download capture, joystick mapper and OSD settings
`timescale 1ns/1ps

module athena_ctrl_top (
	input  logic                                clk_53p6,
	input  logic                                rst,
	input  athena_cfg_pkg::ioctl_t              ioctl,
	input  athena_cfg_pkg::osd_status_t         status,
	input  athena_ctrl_pkg::joy_word_u          joy_usb1,
	input  athena_ctrl_pkg::joy_word_u          joy_usb2,
	input  athena_ctrl_pkg::joy_word_u          joy_db15_1,
	input  athena_ctrl_pkg::joy_word_u          joy_db15_2,
	input  athena_ctrl_pkg::analog_t            analog_l,
	input  athena_ctrl_pkg::analog_t            analog_r,
	output athena_cfg_pkg::dsw_t                dsw,
	output athena_ctrl_pkg::player_word_t       player1,
	output athena_ctrl_pkg::player_word_t       player2,
	output athena_ctrl_pkg::trackball_t         trackball1,
	output athena_ctrl_pkg::trackball_t         trackball2,
	output logic                                pause_req,
	output logic [athena_cfg_pkg::ASPECT_W-1:0] video_arx,
	output logic [athena_cfg_pkg::ASPECT_W-1:0] video_ary,
	output logic                                vga_scaler,
	output logic [2:0]                          layer_ena,
	output logic                                core_flip_hack,
	output logic [15:0]                         menu_mask
);

	// Captured game id, feeds mapper and menu
	athena_cfg_pkg::game_id_t game;

	ioctl_cfg_capture u_ioctl_cfg_capture (
		.clk_53p6 (clk_53p6),
		.rst      (rst),
		.ioctl    (ioctl),
		.dsw      (dsw),
		.game     (game)
	);

	joystick_mapper u_joystick_mapper (
		.clk_53p6   (clk_53p6),
		.rst        (rst),
		.game       (game),
		.db15_mode  (status.db15_mode),
		.joy_usb1   (joy_usb1),
		.joy_usb2   (joy_usb2),
		.joy_db15_1 (joy_db15_1),
		.joy_db15_2 (joy_db15_2),
		.analog_l   (analog_l),
		.analog_r   (analog_r),
		.player1    (player1),
		.player2    (player2),
		.trackball1 (trackball1),
		.trackball2 (trackball2),
		.pause_req  (pause_req)
	);

	osd_settings_out u_osd_settings_out (
		.clk_53p6       (clk_53p6),
		.rst            (rst),
		.status         (status),
		.game           (game),
		.video_arx      (video_arx),
		.video_ary      (video_ary),
		.vga_scaler     (vga_scaler),
		.layer_ena      (layer_ena),
		.core_flip_hack (core_flip_hack),
		.menu_mask      (menu_mask)
	);

endmodule

/* hw/ioctl_cfg_capture.sv */
// Captures DIP switch bytes and the game identifier from host download writes
`timescale 1ns/1ps

module ioctl_cfg_capture (
	input  logic                     clk_53p6,
	input  logic                     rst,
	input  athena_cfg_pkg::ioctl_t   ioctl,
	output athena_cfg_pkg::dsw_t     dsw,
	output athena_cfg_pkg::game_id_t game
);

	// ==================================================
	// Write decode
	// ==================================================

	// Accepted beat
	logic wr_ok;
	// One enable per DIP byte
	logic [athena_cfg_pkg::DIP_BYTES-1:0] dip_wr;
	logic game_wr;

	// DIP byte store
	logic [7:0] dip [athena_cfg_pkg::DIP_BYTES];

	assign wr_ok = ioctl.download && ioctl.wr;

	// Address match per byte also rules out addr >= DIP_BYTES
	always_comb begin
		for (int i = 0; i < athena_cfg_pkg::DIP_BYTES; i++) begin
			dip_wr[i] = wr_ok && (ioctl.index == athena_cfg_pkg::IDX_DIP) &&
				(ioctl.addr == 25'(i));
		end
	end

	// Game id lives at index 1 offset 0
	assign game_wr = wr_ok && (ioctl.index == athena_cfg_pkg::IDX_GAME) &&
		(ioctl.addr == '0);

	// ==================================================
	// Registers
	// ==================================================

	always_ff @(posedge clk_53p6) begin
		if (rst) begin
			// Switches read open until the MRA loads them
			for (int i = 0; i < athena_cfg_pkg::DIP_BYTES; i++) begin
				dip[i] <= 8'hff;
			end
			game <= '0;
		end else begin
			for (int i = 0; i < athena_cfg_pkg::DIP_BYTES; i++) begin
				if (dip_wr[i]) begin
					dip[i] <= ioctl.dout;
				end
			end
			if (game_wr) begin
				game <= ioctl.dout;
			end
		end
	end

	// Core only uses the first two banks
	always_comb begin
		dsw.dsw1 = dip[0];
		dsw.dsw2 = dip[1];
	end

	// Byte moves only one cycle after its own write, to the written data
	for (genvar gi = 0; gi < athena_cfg_pkg::DIP_BYTES; gi++) begin : g_dip_chk
		a_dip_write_only : assert property (
			@(posedge clk_53p6) disable iff (rst)
			!$stable(dip[gi]) |-> ($past(dip_wr[gi]) && (dip[gi] == $past(ioctl.dout)))
		) else $error("DIP byte %0d changed without a matching write", gi);
	end

endmodule

/* hw/joystick_mapper.sv */
// Selects USB or DB15 per player and registers player words, pause request and trackball
`timescale 1ns/1ps

module joystick_mapper (
	input  logic                          clk_53p6,
	input  logic                          rst,
	input  athena_cfg_pkg::game_id_t      game,
	input  logic [1:0]                    db15_mode,
	input  athena_ctrl_pkg::joy_word_u    joy_usb1,
	input  athena_ctrl_pkg::joy_word_u    joy_usb2,
	input  athena_ctrl_pkg::joy_word_u    joy_db15_1,
	input  athena_ctrl_pkg::joy_word_u    joy_db15_2,
	input  athena_ctrl_pkg::analog_t      analog_l,
	input  athena_ctrl_pkg::analog_t      analog_r,
	output athena_ctrl_pkg::player_word_t player1,
	output athena_ctrl_pkg::player_word_t player2,
	output athena_ctrl_pkg::trackball_t   trackball1,
	output athena_ctrl_pkg::trackball_t   trackball2,
	output logic                          pause_req
);

	// ==================================================
	// Decode helpers
	// ==================================================

	// Active low player word from the chosen layout
	function automatic athena_ctrl_pkg::player_word_t build_word(
		input athena_ctrl_pkg::joy_word_u joy_u,
		input athena_ctrl_pkg::joy_word_u joy_d,
		input logic                       use_db15
	);
		athena_ctrl_pkg::player_word_t w;
		// Fixed bits stay high
		w = '1;
		if (use_db15) begin
			w.up      = ~joy_d.db15.up;
			w.down    = ~joy_d.db15.down;
			w.right   = ~joy_d.db15.right;
			w.left    = ~joy_d.db15.left;
			w.btn1    = ~joy_d.db15.b;
			w.btn2    = ~joy_d.db15.c;
			w.start   = ~joy_d.db15.start;
			w.coin    = ~joy_d.db15.select;
			// Select plus B acts as service
			w.service = ~(joy_d.db15.b & joy_d.db15.select);
		end else begin
			w.up      = ~joy_u.usb.up;
			w.down    = ~joy_u.usb.down;
			w.right   = ~joy_u.usb.right;
			w.left    = ~joy_u.usb.left;
			w.btn1    = ~joy_u.usb.btn1;
			w.btn2    = ~joy_u.usb.btn2;
			w.start   = ~joy_u.usb.start;
			w.coin    = ~joy_u.usb.coin;
			w.service = ~joy_u.usb.service;
		end
		return w;
	endfunction

	// Select plus A on DB15 doubles as pause
	function automatic logic pause_of(
		input athena_ctrl_pkg::joy_word_u joy_u,
		input athena_ctrl_pkg::joy_word_u joy_d,
		input logic                       use_db15
	);
		return use_db15 ? (joy_d.db15.a & joy_d.db15.select) : joy_u.usb.pause;
	endfunction

	// Stick position straight onto the trackball inputs
	function automatic athena_ctrl_pkg::trackball_t track_of(
		input athena_ctrl_pkg::analog_t stick
	);
		athena_ctrl_pkg::trackball_t t;
		t.zero_y = 1'b0;
		t.y      = stick.y[7:1];
		t.zero_x = 1'b0;
		// X runs the other way on the cabinet
		t.x      = ~stick.x[7:1];
		return t;
	endfunction

	// ==================================================
	// Source select and output registers
	// ==================================================

	// Country Golf has no DB15 support
	logic [1:0] db15_en;

	assign db15_en = (game == athena_cfg_pkg::GAME_COUNTRY_GOLF) ? 2'b00 : db15_mode;

	always_ff @(posedge clk_53p6) begin
		if (rst) begin
			// Nothing pressed
			player1    <= '1;
			player2    <= '1;
			pause_req  <= 1'b0;
			trackball1 <= '0;
			trackball2 <= '0;
		end else begin
			player1    <= build_word(joy_usb1, joy_db15_1, db15_en[0]);
			player2    <= build_word(joy_usb2, joy_db15_2, db15_en[1]);
			pause_req  <= pause_of(joy_usb1, joy_db15_1, db15_en[0]) |
				pause_of(joy_usb2, joy_db15_2, db15_en[1]);
			trackball1 <= track_of(analog_l);
			trackball2 <= track_of(analog_r);
		end
	end

	// Core reads the unused bits as released buttons
	a_ones_fixed : assert property (
		@(posedge clk_53p6) disable iff (rst)
		(player1.ones_hi == 2'b11) && (player1.ones_lo == 5'h1f) &&
		(player2.ones_hi == 2'b11) && (player2.ones_lo == 5'h1f)
	) else $error("Fixed ones bits of a player word dropped low");

endmodule

/* hw/osd_settings_out.sv */
// Turns the host status word into video aspect, layer enables, flip hack and menu mask
`timescale 1ns/1ps

module osd_settings_out (
	input  logic                                clk_53p6,
	input  logic                                rst,
	input  athena_cfg_pkg::osd_status_t         status,
	input  athena_cfg_pkg::game_id_t            game,
	output logic [athena_cfg_pkg::ASPECT_W-1:0] video_arx,
	output logic [athena_cfg_pkg::ASPECT_W-1:0] video_ary,
	output logic                                vga_scaler,
	output logic [2:0]                          layer_ena,
	output logic                                core_flip_hack,
	output logic [15:0]                         menu_mask
);

	// ==================================================
	// Aspect ratio
	// ==================================================

	always_comb begin
		if (status.aspect == 2'd0) begin
			// Original ratio follows orientation
			if (status.orient_vert) begin
				video_arx = athena_cfg_pkg::ASPECT_W'(3);
				video_ary = athena_cfg_pkg::ASPECT_W'(4);
			end else begin
				video_arx = athena_cfg_pkg::ASPECT_W'(4);
				video_ary = athena_cfg_pkg::ASPECT_W'(3);
			end
		end else begin
			// Full screen and ARC presets pass the code minus one
			video_arx = athena_cfg_pkg::ASPECT_W'(status.aspect) - 1'b1;
			video_ary = '0;
		end
	end

	// Straight from the menu
	assign vga_scaler = status.vga_scaler;

	// ==================================================
	// Registered settings
	// ==================================================

	always_ff @(posedge clk_53p6) begin
		if (rst) begin
			layer_ena      <= 3'b111;
			core_flip_hack <= 1'b0;
			menu_mask      <= athena_cfg_pkg::MENU_MASK_DEFAULT;
		end else begin
			// Bit 0 side, bit 1 back, bit 2 front
			layer_ena      <= ~status.layer_off;
			core_flip_hack <= status.core_flip;
			// Flip hack entry shown for Athena only
			if (game == athena_cfg_pkg::GAME_ATHENA) begin
				menu_mask <= athena_cfg_pkg::MENU_MASK_DEFAULT & ~16'h0001;
			end else begin
				menu_mask <= athena_cfg_pkg::MENU_MASK_DEFAULT;
			end
		end
	end

	// Ratio codes never exceed 4:3 or ARC index
	a_arx_small : assert property (
		@(posedge clk_53p6) disable iff (rst)
		video_arx < athena_cfg_pkg::ASPECT_W'(8)
	) else $error("video_arx out of range %0h", video_arx);

endmodule

/* sim/athena_ctrl_model.svh */
// Reference model functions and typed compare tasks, included inside the testbench module
`ifndef ATHENA_CTRL_MODEL_SVH
`define ATHENA_CTRL_MODEL_SVH

// ==================================================
// Reference model
// ==================================================

// Active low player word straight from raw joystick bit positions
function automatic athena_ctrl_pkg::player_word_t player_from_joy(
	input logic [15:0] j,
	input logic        db15
);
	logic [15:0] w;
	w = 16'hffff;
	// Directions sit on the same bits in both layouts
	w[13] = ~j[3];
	w[12] = ~j[2];
	w[11] = ~j[0];
	w[10] = ~j[1];
	if (db15) begin
		// B with select means service
		w[9] = ~(j[5] & j[11]);
		// btn2 c, btn1 b, start, coin select
		w[3:0] = ~{j[6], j[5], j[10], j[11]};
	end else begin
		w[9] = ~j[8];
		w[3:0] = ~{j[5], j[4], j[6], j[7]};
	end
	return w;
endfunction

// USB pause bit, or A with select on DB15
function automatic logic pause_from_joy(input logic [15:0] j, input logic db15);
	return db15 ? (j[4] & j[11]) : j[9];
endfunction

// Upper seven bits of each stick byte, x mirrored
function automatic athena_ctrl_pkg::trackball_t ball_from_stick(input logic [15:0] a);
	return {1'b0, a[15:9], 1'b0, ~a[7:1]};
endfunction

// Aspect pair as {arx, ary}
function automatic logic [25:0] aspect_pair(input logic [31:0] s);
	if (s[9:8] == 2'd0) begin
		return s[10] ? {13'd3, 13'd4} : {13'd4, 13'd3};
	end
	return {13'(s[9:8]) - 13'd1, 13'd0};
endfunction

// Menu bit 0 hidden for Athena
function automatic logic [15:0] menu_for_game(input logic [7:0] g);
	return (g == athena_cfg_pkg::GAME_ATHENA) ? 16'h00fe : 16'h00ff;
endfunction

// ==================================================
// Compare tasks
// ==================================================

task automatic check_dsw(input athena_cfg_pkg::dsw_t got, input athena_cfg_pkg::dsw_t exp);
	if (got !== exp) fail_run($sformatf("[FAIL] dsw got 0x%04h expected 0x%04h", got, exp));
endtask

task automatic check_player(input string name, input athena_ctrl_pkg::player_word_t got,
	input athena_ctrl_pkg::player_word_t exp);
	if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp));
endtask

task automatic check_trackball(input string name, input athena_ctrl_pkg::trackball_t got,
	input athena_ctrl_pkg::trackball_t exp);
	if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp));
endtask

task automatic check_pause(input logic got, input logic exp);
	if (got !== exp) fail_run($sformatf("[FAIL] pause_req got 0x%0h expected 0x%0h", got, exp));
endtask

// Aspect, layer, flip and mask values, widened to 16 bits
task automatic check_settings(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp) fail_run($sformatf("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp));
endtask

`endif

/* sim/athena_ctrl_tb.sv */
// Seeded random testbench for the control glue, every output checked against the included model
`timescale 1ns/1ps

module athena_ctrl_tb;

	logic clk_53p6;
	logic rst;
	athena_cfg_pkg::ioctl_t         ioctl;
	athena_cfg_pkg::osd_status_t    status;
	athena_ctrl_pkg::joy_word_u     joy_usb1, joy_usb2, joy_db15_1, joy_db15_2;
	athena_ctrl_pkg::analog_t       analog_l, analog_r;
	athena_cfg_pkg::dsw_t           dsw;
	athena_ctrl_pkg::player_word_t  player1, player2;
	athena_ctrl_pkg::trackball_t    trackball1, trackball2;
	logic                           pause_req;
	logic [12:0]                    video_arx, video_ary;
	logic                           vga_scaler;
	logic [2:0]                     layer_ena;
	logic                           core_flip_hack;
	logic [15:0]                    menu_mask;

	// Model state mirrors the capture registers
	logic [7:0] dip_m [8];
	logic [7:0] game_m;
	// Inputs the DUT sampled on the last edge
	athena_cfg_pkg::ioctl_t      p_io;
	athena_cfg_pkg::osd_status_t p_status;
	logic [15:0] p_usb1, p_usb2, p_db1, p_db2, p_ana_l, p_ana_r;

	athena_ctrl_top u_athena_ctrl_top (.*);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "athena_ctrl_model.svh"

	// ==================================================
	// Clock, reset, watchdog
	// ==================================================

	initial begin
		clk_53p6 = 1'b0;
		forever #2 clk_53p6 = ~clk_53p6;
	end

	initial begin
		repeat (8) @(posedge clk_53p6);
		rst <= 1'b0;
	end

	initial begin
		#100000;
		fail_run("Simulation ran past its time limit");
	end

	// One cycle: drive on the rising edge, check on the falling edge
	task automatic do_step(input bit io_rnd, input int st_kind, input athena_cfg_pkg::ioctl_t io_fix);
		athena_cfg_pkg::ioctl_t      io;
		athena_cfg_pkg::osd_status_t st;
		logic [1:0]  en;
		logic [15:0] j1;
		logic [15:0] j2;
		logic [25:0] asp;
		io = io_fix;
		if (io_rnd) begin
			io.download = 1'($urandom);
			io.wr = 1'($urandom);
			// Mostly DIP index, some game and stray indexes
			case ($urandom % 4)
				0: io.index = 8'($urandom);
				1: io.index = athena_cfg_pkg::IDX_GAME;
				default: io.index = athena_cfg_pkg::IDX_DIP;
			endcase
			io.addr = 25'($urandom % 12);
			io.dout = 8'($urandom);
		end
		st = '0;
		if (st_kind == 1) st.db15_mode = 2'($urandom);
		if (st_kind == 2) st = 32'($urandom);
		@(posedge clk_53p6);
		ioctl <= io;
		status <= st;
		joy_usb1 <= 16'($urandom);
		joy_usb2 <= 16'($urandom);
		joy_db15_1 <= 16'($urandom);
		joy_db15_2 <= 16'($urandom);
		analog_l <= 16'($urandom);
		analog_r <= 16'($urandom);
		@(negedge clk_53p6);
		// Registered outputs saw last inputs and the game held before this edge
		en = (game_m == athena_cfg_pkg::GAME_COUNTRY_GOLF) ? 2'b00 : p_status[21:20];
		j1 = en[0] ? p_db1 : p_usb1;
		j2 = en[1] ? p_db2 : p_usb2;
		check_player("player1", player1, player_from_joy(j1, en[0]));
		check_player("player2", player2, player_from_joy(j2, en[1]));
		check_pause(pause_req, pause_from_joy(j1, en[0]) | pause_from_joy(j2, en[1]));
		check_trackball("trackball1", trackball1, ball_from_stick(p_ana_l));
		check_trackball("trackball2", trackball2, ball_from_stick(p_ana_r));
		check_settings("layer_ena", 16'(layer_ena), {13'd0, ~p_status[18:16]});
		check_settings("core_flip_hack", 16'(core_flip_hack), 16'(p_status[19]));
		check_settings("menu_mask", menu_mask, menu_for_game(game_m));
		// Capture applies last beat
		if (p_io.download && p_io.wr) begin
			if (p_io.index == 8'd254 && p_io.addr < 25'd8) dip_m[p_io.addr[2:0]] = p_io.dout;
			if (p_io.index == 8'd1 && p_io.addr == 25'd0) game_m = p_io.dout;
		end
		check_dsw(dsw, {dip_m[1], dip_m[0]});
		// Combinational settings follow the live status
		asp = aspect_pair(status);
		check_settings("video_arx", 16'(video_arx), 16'(asp[25:13]));
		check_settings("video_ary", 16'(video_ary), 16'(asp[12:0]));
		check_settings("vga_scaler", 16'(vga_scaler), 16'(status[14]));
		p_io = ioctl;
		p_status = status;
		p_usb1 = joy_usb1;
		p_usb2 = joy_usb2;
		p_db1 = joy_db15_1;
		p_db2 = joy_db15_2;
		p_ana_l = analog_l;
		p_ana_r = analog_r;
	endtask

	// Game id write, then steps until the model holds it
	task automatic write_game(input logic [7:0] g, input int st_kind);
		athena_cfg_pkg::ioctl_t io;
		int n;
		io = '0;
		io.download = 1'b1;
		io.wr = 1'b1;
		io.index = athena_cfg_pkg::IDX_GAME;
		io.dout = g;
		do_step(1'b0, st_kind, io);
		n = 0;
		while (game_m !== g) begin
			do_step(1'b0, st_kind, '0);
			n++;
			if (n > 4) fail_run("Game write was never taken by the capture registers");
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		int n;
		void'($urandom(32'hf9c0));
		rst = 1'b1;
		ioctl = '0;
		status = '0;
		joy_usb1 = '0;
		joy_usb2 = '0;
		joy_db15_1 = '0;
		joy_db15_2 = '0;
		analog_l = '0;
		analog_r = '0;
		game_m = '0;
		for (int i = 0; i < 8; i++) dip_m[i] = 8'hff;
		p_io = '0;
		p_status = '0;
		{p_usb1, p_usb2, p_db1, p_db2, p_ana_l, p_ana_r} = '0;
		n = 0;
		while (rst !== 1'b0) begin
			@(negedge clk_53p6);
			n++;
			if (n > 20) fail_run("Reset was never released");
		end
		// After reset, nothing pressed and defaults out
		check_dsw(dsw, 16'hffff);
		check_player("player1", player1, 16'hffff);
		check_player("player2", player2, 16'hffff);
		check_pause(pause_req, 1'b0);
		check_trackball("trackball1", trackball1, '0);
		check_trackball("trackball2", trackball2, '0);
		check_settings("layer_ena", 16'(layer_ena), 16'h0007);
		check_settings("core_flip_hack", 16'(core_flip_hack), 16'h0000);
		check_settings("menu_mask", menu_mask, 16'h00ff);
		repeat (200) do_step(1'b1, 0, '0);
		repeat (200) do_step(1'b0, 0, '0);
		repeat (200) do_step(1'b0, 1, '0);
		// Country Golf forces USB on both players
		write_game(athena_cfg_pkg::GAME_COUNTRY_GOLF, 1);
		repeat (100) do_step(1'b0, 1, '0);
		write_game(athena_cfg_pkg::GAME_ATHENA, 2);
		repeat (200) do_step(1'b0, 2, '0);
		write_game(8'h00, 2);
		repeat (50) do_step(1'b0, 2, '0);
		$display("Testbench passed");
		$finish;
	end

endmodule
